/* all.f */
ex_pkg.sv
ex_alu.sv
ex_branch.sv
ex_csr.sv
ex_lsu.sv
ex_writeback.sv
ex_unit.sv
ex_assert.sv
ex_tb.sv

/* ex_tb.sv */
`timescale 1ns/10ps

module ex_tb;
    import ex_pkg::*;

    localparam int    n_instr      = 2000;
    localparam int    reset_cycles = 8;
    // one cycle per instruction, plus reset and some slack
    localparam int    cycle_limit  = n_instr + reset_cycles + 92;
    localparam word_t mstatus_init = 64'h0000_000a_0000_1800;

    logic      clk = 1'b0;
    logic      rst;
    issue_t    issue_in;
    word_t     mem_rdata;
    word_t     dnpc;
    logic      pc_update;
    word_t     pc_out;
    inst_u     inst_out;
    rd_write_t rd_wr;
    mem_req_t  mem_req;

    // shadow state
    word_t     mem [64];
    word_t     sh_mtvec;
    word_t     sh_mepc;
    word_t     sh_mcause;
    word_t     sh_mstatus;
    int        cycles = 0;
    issue_t    pending;
    word_t     e_dnpc;
    logic      e_pcu;
    rd_write_t e_rd;
    mem_req_t  e_mem;
    string     tag;

    alu_mode_t modes [10] = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
                              alu_or, alu_xor, alu_sll, alu_srl, alu_sra};

    ex_unit UUT (
        .clk       (clk),
        .rst       (rst),
        .issue_in  (issue_in),
        .mem_rdata (mem_rdata),
        .dnpc      (dnpc),
        .pc_update (pc_update),
        .pc_out    (pc_out),
        .inst_out  (inst_out),
        .rd_wr     (rd_wr),
        .mem_req   (mem_req)
    );

    bind ex_unit ex_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .pc_update (pc_update),
        .mem_req   (mem_req)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run went past %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    //********************************************************************
    // memory model, 64 doublewords
    //********************************************************************
    assign mem_rdata = mem[mem_req.addr[8:3]];

    always @(posedge clk) begin
        if (!rst && mem_req.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_req.wmask[b]) begin
                    mem[mem_req.addr[8:3]][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    //********************************************************************
    // immediates and reference model
    //********************************************************************
    function automatic word_t sext_i(logic [31:0] w);
        return {{52{w[31]}}, w[31:20]};
    endfunction

    function automatic word_t sext_s(logic [31:0] w);
        return {{52{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic word_t branch_offset(logic [31:0] w);
        return {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic word_t jump_offset(logic [31:0] w);
        return {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic word_t upper_imm(logic [31:0] w);
        return {{32{w[31]}}, w[31:12], 12'b0};
    endfunction

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic word_t alu_ref(alu_mode_t m, word_t a, word_t b);
        case (m)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            alu_sltu: return (a < b) ? 64'd1 : 64'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[5:0];
            alu_srl:  return a >> b[5:0];
            alu_sra:  return word_t'($signed(a) >>> b[5:0]);
            default:  return '0;
        endcase
    endfunction

    // log2 of access bytes
    function automatic int access_size(op_t op);
        case (op)
            op_lh, op_lhu, op_sh: return 1;
            op_lw, op_lwu, op_sw: return 2;
            op_ld, op_sd:         return 3;
            default:              return 0;
        endcase
    endfunction

    function automatic logic [7:0] byte_mask(int size);
        case (size)
            0:       return 8'h01;
            1:       return 8'h03;
            2:       return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

    // one full byte of ones per mask bit
    function automatic word_t lane_bits(logic [7:0] m);
        word_t bits;
        bits = '0;
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                bits[b*8 +: 8] = 8'hff;
            end
        end
        return bits;
    endfunction

    function automatic word_t load_ref(op_t op, word_t line, logic [2:0] off);
        word_t lane;
        lane = line >> (8 * off);
        case (op)
            op_lb:   return {{56{lane[7]}}, lane[7:0]};
            op_lh:   return {{48{lane[15]}}, lane[15:0]};
            op_lw:   return {{32{lane[31]}}, lane[31:0]};
            op_lbu:  return {56'b0, lane[7:0]};
            op_lhu:  return {48'b0, lane[15:0]};
            op_lwu:  return {32'b0, lane[31:0]};
            default: return lane;
        endcase
    endfunction

    function automatic word_t csr_ref(logic [11:0] a);
        case (a)
            12'h305: return sh_mtvec;
            12'h341: return sh_mepc;
            12'h342: return sh_mcause;
            12'h300: return sh_mstatus;
            default: return '0;
        endcase
    endfunction

    task automatic predict(input issue_t t, output word_t dn, output logic pcu,
                           output rd_write_t rd, output mem_req_t mr);
        op_t   op;
        word_t res;
        word_t diff;
        word_t snpc;
        word_t btgt;
        op   = t.valid ? t.op : op_nop;
        res  = alu_ref(t.alu_mode, t.opnd_a, t.opnd_b);
        diff = t.rs1_val - t.rs2_val;
        snpc = t.pc + 64'd4;
        btgt = t.pc + branch_offset(t.inst);
        dn   = snpc;
        pcu  = (op != op_nop);
        rd   = '0;
        mr   = '0;
        rd.id  = t.inst[11:7];
        rd.wen = op inside {op_alu, op_aluw, op_lui, op_jal, op_jalr, op_lb, op_lh,
                            op_lw, op_lbu, op_lhu, op_lwu, op_ld, op_csrrw, op_csrrs};
        case (op)
            op_alu:  rd.value = res;
            op_aluw: rd.value = {{32{res[31]}}, res[31:0]};
            op_lui:  rd.value = upper_imm(t.inst);
            op_jal, op_jalr: begin
                dn       = (op == op_jalr) ? {res[63:1], 1'b0} : res;
                rd.value = snpc;
            end
            // branch rules on rs1 - rs2
            op_beq:  dn = (diff == '0) ? btgt : snpc;
            op_bne:  dn = (diff != '0) ? btgt : snpc;
            op_blt:  dn = diff[63] ? btgt : snpc;
            op_bge:  dn = !diff[63] ? btgt : snpc;
            op_bltu: dn = (t.rs1_val < t.rs2_val) ? btgt : snpc;
            op_bgeu: dn = (t.rs1_val >= t.rs2_val) ? btgt : snpc;
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: begin
                mr.ren   = 1'b1;
                mr.addr  = res;
                rd.value = load_ref(op, mem[res[8:3]], res[2:0]);
            end
            op_sb, op_sh, op_sw, op_sd: begin
                mr.wen   = 1'b1;
                mr.addr  = res;
                mr.wmask = byte_mask(access_size(op)) << res[2:0];
                mr.wdata = (t.rs2_val << (8 * res[2:0])) & lane_bits(mr.wmask);
            end
            op_csrrw, op_csrrs: rd.value = csr_ref(t.inst[31:20]);
            op_ecall: dn = sh_mtvec;
            op_mret:  dn = sh_mepc;
            default: ;
        endcase
    endtask

    // csr side effects land at the end of the output cycle
    task automatic commit_csr(input issue_t t);
        op_t         op;
        logic [11:0] a;
        word_t       v;
        op = t.valid ? t.op : op_nop;
        a  = t.inst[31:20];
        v  = (op == op_csrrs) ? (csr_ref(a) | t.rs1_val) : t.rs1_val;
        if (op == op_csrrw || op == op_csrrs) begin
            case (a)
                12'h305: sh_mtvec   = v;
                12'h341: sh_mepc    = v;
                12'h342: sh_mcause  = v;
                12'h300: sh_mstatus = v;
                default: ;
            endcase
        end
        if (op == op_ecall) begin
            sh_mepc   = t.pc;
            sh_mcause = 64'd11;
        end
    endtask

    //********************************************************************
    // compare tasks
    //********************************************************************
    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic compare_inst(input string name, input inst_u exp, input inst_u act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "instruction mismatch");
        end
    endtask

    // id and value only matter when wen is set
    task automatic compare_rd(input string name, input rd_write_t exp, input rd_write_t act);
        rd_write_t seen;
        rd_write_t want;
        seen = act;
        want = exp;
        if (!seen.wen) begin
            seen.id    = '0;
            seen.value = '0;
        end
        if (!want.wen) begin
            want.id    = '0;
            want.value = '0;
        end
        if (seen !== want) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "rd write mismatch");
        end
    endtask

    // only bytes under wmask carry data
    task automatic compare_mem(input string name, input mem_req_t exp, input mem_req_t act);
        mem_req_t seen;
        seen = act;
        if (!seen.ren && !seen.wen) begin
            seen.addr = '0;
        end
        for (int b = 0; b < 8; b++) begin
            if (!seen.wmask[b]) begin
                seen.wdata[b*8 +: 8] = 8'h00;
            end
        end
        if (seen !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "memory request mismatch");
        end
    endtask

    //********************************************************************
    // stimulus
    //********************************************************************
    task automatic make_issue(output issue_t t);
        logic [31:0] w;
        word_t       addr;
        w          = $urandom;
        t          = '0;
        t.valid    = ($urandom_range(0, 15) != 0);
        t.op       = op_t'($urandom_range(0, 26));
        t.pc       = rand_word() & ~64'h3;
        t.alu_mode = alu_add;
        t.rs1_val  = rand_word();
        // equal sources now and then so beq and bge get taken
        t.rs2_val  = ($urandom_range(0, 3) == 0) ? t.rs1_val : rand_word();
        t.opnd_a   = t.rs1_val;
        t.opnd_b   = t.rs2_val;
        // aligned address inside the 512 byte model
        addr = word_t'($urandom_range(0, 511)) & ~word_t'((1 << access_size(t.op)) - 1);
        case (t.op)
            op_alu, op_aluw: t.alu_mode = modes[$urandom_range(0, 9)];
            op_jal: begin
                t.opnd_a = t.pc;
                t.opnd_b = jump_offset(w);
            end
            op_jalr: t.opnd_b = sext_i(w);
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: t.alu_mode = alu_sub;
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: begin
                t.opnd_b = sext_i(w);
                t.opnd_a = addr - t.opnd_b;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                t.opnd_b = sext_s(w);
                t.opnd_a = addr - t.opnd_b;
            end
            op_csrrw, op_csrrs: begin
                case ($urandom_range(0, 4))
                    0:       w[31:20] = 12'h305;
                    1:       w[31:20] = 12'h341;
                    2:       w[31:20] = 12'h342;
                    3:       w[31:20] = 12'h300;
                    default: w[31:20] = 12'($urandom);
                endcase
            end
            default: ;
        endcase
        t.inst = w;
    endtask

    initial begin
        void'($urandom(50178));
        for (int i = 0; i < 64; i++) begin
            mem[i] = word_t'(i + 1) * 64'h9e37_79b9_7f4a_7c15;
        end
        sh_mtvec   = '0;
        sh_mepc    = '0;
        sh_mcause  = '0;
        sh_mstatus = mstatus_init;
        rst        = 1'b1;
        issue_in   = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        // state right after reset
        compare_word("reset dnpc", 64'd4, dnpc);
        compare_flag("reset pc_update", 1'b0, pc_update);
        compare_rd("reset rd_wr", '0, rd_wr);
        compare_mem("reset mem_req", '0, mem_req);
        make_issue(pending);
        issue_in = pending;
        for (int n = 0; n < n_instr; n++) begin
            @(posedge clk);
            #1;
            predict(pending, e_dnpc, e_pcu, e_rd, e_mem);
            tag = $sformatf("instr %0d %s", n, pending.valid ? pending.op.name() : "bubble");
            compare_word({tag, " dnpc"}, e_dnpc, dnpc);
            compare_flag({tag, " pc_update"}, e_pcu, pc_update);
            compare_word({tag, " pc_out"}, pending.pc, pc_out);
            compare_inst({tag, " inst_out"}, pending.inst, inst_out);
            compare_rd({tag, " rd_wr"}, e_rd, rd_wr);
            compare_mem({tag, " mem_req"}, e_mem, mem_req);
            commit_csr(pending);
            make_issue(pending);
            issue_in = pending;
        end
        if (UUT.u_assert.fail_count != 0) begin
            $display("concurrent assertions failed %0d times", UUT.u_assert.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* ex_assert.sv */
`timescale 1ns/10ps

module ex_assert (
    input logic             clk,
    input logic             rst,
    input logic             pc_update,
    input ex_pkg::mem_req_t mem_req
);

    int unsigned fail_count = 0;

    // load and store never share a cycle
    rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.ren && mem_req.wen))
        else begin
            fail_count++;
            $error("memory read and write enables high together");
        end

    // no stray byte enables
    mask_idle: assert property (@(posedge clk) disable iff (rst)
        !mem_req.wen |-> (mem_req.wmask == '0))
        else begin
            fail_count++;
            $error("wmask set while write enable is low");
        end

    // cleared issue register holds a nop
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !pc_update)
        else begin
            fail_count++;
            $error("pc_update high in the cycle after reset");
        end

endmodule

/* ex_unit.sv */
`timescale 1ns/10ps

module ex_unit (
    input  logic              clk,
    input  logic              rst,
    input  ex_pkg::issue_t    issue_in,
    input  ex_pkg::word_t     mem_rdata,
    output ex_pkg::word_t     dnpc,
    output logic              pc_update,
    output ex_pkg::word_t     pc_out,
    output ex_pkg::inst_u     inst_out,
    output ex_pkg::rd_write_t rd_wr,
    output ex_pkg::mem_req_t  mem_req
);
    import ex_pkg::*;

    //********************************************************************
    // issue register
    //********************************************************************
    issue_t    issue_next;
    issue_t    cur;
    word_t     alu_result;
    word_t     alu_word;
    word_t     csr_rdata;
    word_t     load_value;
    redirect_t trap;

    // a bubble from decode turns into a nop here
    always_comb begin
        issue_next = issue_in;
        if (!issue_in.valid) begin
            issue_next.op = op_nop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur <= '0;
        end else begin
            cur <= issue_next;
        end
    end

    // any real op moves the pc
    assign pc_update = (cur.op != op_nop);
    assign pc_out    = cur.pc;
    assign inst_out  = cur.inst;

    //********************************************************************
    // units
    //********************************************************************
    ex_alu u_alu (
        .cur        (cur),
        .alu_result (alu_result),
        .alu_word   (alu_word)
    );

    ex_branch u_branch (
        .cur        (cur),
        .alu_result (alu_result),
        .trap       (trap),
        .dnpc       (dnpc)
    );

    ex_csr u_csr (
        .clk        (clk),
        .rst        (rst),
        .cur        (cur),
        .csr_rdata  (csr_rdata),
        .trap       (trap)
    );

    ex_lsu u_lsu (
        .cur        (cur),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .load_value (load_value)
    );

    ex_writeback u_writeback (
        .cur        (cur),
        .alu_result (alu_result),
        .alu_word   (alu_word),
        .load_value (load_value),
        .csr_rdata  (csr_rdata),
        .rd_wr      (rd_wr)
    );

endmodule

/* ex_writeback.sv */
`timescale 1ns/10ps

module ex_writeback (
    input  ex_pkg::issue_t    cur,
    input  ex_pkg::word_t     alu_result,
    input  ex_pkg::word_t     alu_word,
    input  ex_pkg::word_t     load_value,
    input  ex_pkg::word_t     csr_rdata,
    output ex_pkg::rd_write_t rd_wr
);
    import ex_pkg::*;

    // x0 filtering is left to the register file
    assign rd_wr.id = cur.inst.i.rd;

    always_comb begin
        rd_wr.wen   = 1'b1;
        rd_wr.value = '0;
        case (cur.op)
            op_alu:  rd_wr.value = alu_result;
            op_aluw: rd_wr.value = alu_word;
            op_lui:  rd_wr.value = imm_u(cur.inst);
            // link address
            op_jal, op_jalr: begin
                rd_wr.value = cur.pc + 64'd4;
            end
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: begin
                rd_wr.value = load_value;
            end
            // old csr value goes to rd
            op_csrrw, op_csrrs: begin
                rd_wr.value = csr_rdata;
            end
            default: rd_wr.wen = 1'b0;
        endcase
    end

endmodule

/* ex_lsu.sv */
`timescale 1ns/10ps

module ex_lsu (
    input  ex_pkg::issue_t   cur,
    input  ex_pkg::word_t    alu_result,
    input  ex_pkg::word_t    mem_rdata,
    output ex_pkg::mem_req_t mem_req,
    output ex_pkg::word_t    load_value
);
    import ex_pkg::*;

    logic       is_load;
    logic       is_store;
    logic [5:0] lane_shift;
    logic [7:0] size_mask;
    word_t      size_bits;
    word_t      lane_data;

    assign is_load    = cur.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld};
    assign is_store   = cur.op inside {op_sb, op_sh, op_sw, op_sd};
    // byte offset inside the doubleword, in bits
    assign lane_shift = {alu_result[2:0], 3'b000};

    //********************************************************************
    // store side
    //********************************************************************
    always_comb begin
        case (cur.op)
            op_sb:   size_mask = 8'h01;
            op_sh:   size_mask = 8'h03;
            op_sw:   size_mask = 8'h0f;
            op_sd:   size_mask = 8'hff;
            default: size_mask = 8'h00;
        endcase
    end

    // expand byte mask to bits so unused rs2 bytes stay zero
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            size_bits[i*8 +: 8] = {8{size_mask[i]}};
        end
    end

    assign mem_req.ren   = is_load;
    assign mem_req.wen   = is_store;
    assign mem_req.addr  = (is_load || is_store) ? alu_result : '0;
    assign mem_req.wdata = (cur.rs2_val & size_bits) << lane_shift;
    assign mem_req.wmask = size_mask << alu_result[2:0];

    //********************************************************************
    // load side
    //********************************************************************
    assign lane_data = mem_rdata >> lane_shift;

    always_comb begin
        case (cur.op)
            op_lb:   load_value = {{(xlen-8){lane_data[7]}}, lane_data[7:0]};
            op_lh:   load_value = {{(xlen-16){lane_data[15]}}, lane_data[15:0]};
            op_lw:   load_value = {{(xlen-32){lane_data[31]}}, lane_data[31:0]};
            op_lbu:  load_value = {{(xlen-8){1'b0}}, lane_data[7:0]};
            op_lhu:  load_value = {{(xlen-16){1'b0}}, lane_data[15:0]};
            op_lwu:  load_value = {{(xlen-32){1'b0}}, lane_data[31:0]};
            op_ld:   load_value = lane_data;
            default: load_value = '0;
        endcase
    end

endmodule

/* ex_csr.sv */
`timescale 1ns/10ps

module ex_csr (
    input  logic              clk,
    input  logic              rst,
    input  ex_pkg::issue_t    cur,
    output ex_pkg::word_t     csr_rdata,
    output ex_pkg::redirect_t trap
);
    import ex_pkg::*;

    word_t                 mtvec;
    word_t                 mepc;
    word_t                 mcause;
    word_t                 mstatus;
    logic [csr_addr_w-1:0] csr_addr;
    logic                  csr_wen;
    word_t                 csr_wdata;

    // csr number sits in the i-type immediate
    assign csr_addr = cur.inst.i.imm;

    always_comb begin
        case (csr_addr)
            csr_mtvec_addr:   csr_rdata = mtvec;
            csr_mepc_addr:    csr_rdata = mepc;
            csr_mcause_addr:  csr_rdata = mcause;
            csr_mstatus_addr: csr_rdata = mstatus;
            default:          csr_rdata = '0;
        endcase
    end

    assign csr_wen   = (cur.op == op_csrrw) || (cur.op == op_csrrs);
    // csrrs sets bits, csrrw replaces
    assign csr_wdata = (cur.op == op_csrrs) ? (csr_rdata | cur.rs1_val) : cur.rs1_val;

    //********************************************************************
    // csr state, written at the end of the output cycle
    //********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= mstatus_reset;
        end else begin
            if (csr_wen) begin
                case (csr_addr)
                    csr_mtvec_addr:   mtvec   <= csr_wdata;
                    csr_mepc_addr:    mepc    <= csr_wdata;
                    csr_mcause_addr:  mcause  <= csr_wdata;
                    csr_mstatus_addr: mstatus <= csr_wdata;
                    default: ;
                endcase
            end
            // ecall saves its own pc
            if (cur.op == op_ecall) begin
                mepc   <= cur.pc;
                mcause <= cause_ecall_m;
            end
        end
    end

    // trap entry and return
    assign trap.valid  = (cur.op == op_ecall) || (cur.op == op_mret);
    assign trap.target = (cur.op == op_ecall) ? mtvec : mepc;

endmodule

/* ex_branch.sv */
`timescale 1ns/10ps

module ex_branch (
    input  ex_pkg::issue_t    cur,
    input  ex_pkg::word_t     alu_result,
    input  ex_pkg::redirect_t trap,
    output ex_pkg::word_t     dnpc
);
    import ex_pkg::*;

    word_t snpc;
    word_t btarget;
    logic  res_zero;
    logic  res_neg;

    assign snpc     = cur.pc + 64'd4;
    assign btarget  = cur.pc + imm_b(cur.inst);
    // beq/bne/blt/bge look at rs1 - rs2 from the alu
    assign res_zero = (alu_result == '0);
    assign res_neg  = alu_result[xlen-1];

    always_comb begin
        if (trap.valid) begin
            dnpc = trap.target;
        end else begin
            case (cur.op)
                op_jal:  dnpc = alu_result;
                op_jalr: dnpc = {alu_result[xlen-1:1], 1'b0};
                op_beq:  dnpc = res_zero ? btarget : snpc;
                op_bne:  dnpc = !res_zero ? btarget : snpc;
                op_blt:  dnpc = res_neg ? btarget : snpc;
                op_bge:  dnpc = !res_neg ? btarget : snpc;
                // unsigned forms compare the raw sources
                op_bltu: dnpc = (cur.rs1_val < cur.rs2_val) ? btarget : snpc;
                op_bgeu: dnpc = (cur.rs1_val >= cur.rs2_val) ? btarget : snpc;
                default: dnpc = snpc;
            endcase
        end
    end

endmodule

/* ex_alu.sv */
`timescale 1ns/10ps

module ex_alu (
    input  ex_pkg::issue_t cur,
    output ex_pkg::word_t  alu_result,
    output ex_pkg::word_t  alu_word
);
    import ex_pkg::*;

    word_t      a;
    word_t      b;
    logic [5:0] shamt;

    // operands were already picked by decode
    assign a     = cur.opnd_a;
    assign b     = cur.opnd_b;
    assign shamt = b[5:0];

    always_comb begin
        case (cur.alu_mode)
            alu_add:  alu_result = a + b;
            alu_sub:  alu_result = a - b;
            // compares give 0 or 1
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, a < b};
            alu_and:  alu_result = a & b;
            alu_or:   alu_result = a | b;
            alu_xor:  alu_result = a ^ b;
            alu_sll:  alu_result = a << shamt;
            alu_srl:  alu_result = a >> shamt;
            alu_sra:  alu_result = $signed(a) >>> shamt;
            default:  alu_result = '0;
        endcase
    end

    // low word, sign extended for the *w forms
    assign alu_word = {{(xlen-32){alu_result[31]}}, alu_result[31:0]};

endmodule

/* ex_pkg.sv */
package ex_pkg;

    //********************************************************************
    // widths and csr map
    //********************************************************************
    localparam int xlen       = 64;
    localparam int reg_idx_w  = 5;
    localparam int csr_addr_w = 12;

    localparam logic [csr_addr_w-1:0] csr_mtvec_addr   = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc_addr    = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause_addr  = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mstatus_addr = 12'h300;

    // mpp = machine, plus uxl/sxl fields
    localparam logic [xlen-1:0] mstatus_reset = 64'h0000_000a_0000_1800;
    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

    typedef logic [xlen-1:0] word_t;

    // decoded operation, op_nop must stay at code 0
    typedef enum logic [5:0] {
        op_nop, op_alu, op_aluw, op_lui, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
        op_sb, op_sh, op_sw, op_sd,
        op_csrrw, op_csrrs, op_ecall, op_mret
    } op_t;

    // alu codes as used by decode
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_mode_t;

    //********************************************************************
    // instruction word views
    //********************************************************************
    typedef struct packed {
        logic [11:0]          imm;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } inst_s_t;

    // raw slices for b, j and u immediates
    typedef struct packed {
        logic       b31;
        logic [5:0] b30_25;
        logic [3:0] b24_21;
        logic       b20;
        logic [7:0] b19_12;
        logic [3:0] b11_8;
        logic       b7;
        logic [6:0] opcode;
    } inst_raw_t;

    typedef union packed {
        inst_i_t   i;
        inst_s_t   s;
        inst_raw_t raw;
    } inst_u;

    // immediates, all sign extended from bit 31
    function automatic word_t imm_i(inst_u inst);
        return {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic word_t imm_s(inst_u inst);
        return {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

    function automatic word_t imm_b(inst_u inst);
        return {{(xlen-13){inst.raw.b31}}, inst.raw.b31, inst.raw.b7,
                inst.raw.b30_25, inst.raw.b11_8, 1'b0};
    endfunction

    function automatic word_t imm_j(inst_u inst);
        return {{(xlen-21){inst.raw.b31}}, inst.raw.b31, inst.raw.b19_12,
                inst.raw.b20, inst.raw.b30_25, inst.raw.b24_21, 1'b0};
    endfunction

    function automatic word_t imm_u(inst_u inst);
        return {{(xlen-32){inst.raw.b31}}, inst.raw.b31, inst.raw.b30_25,
                inst.raw.b24_21, inst.raw.b20, inst.raw.b19_12, 12'b0};
    endfunction

    //********************************************************************
    // stage ports
    //********************************************************************
    typedef struct packed {
        logic      valid;
        word_t     pc;
        inst_u     inst;
        op_t       op;
        alu_mode_t alu_mode;
        word_t     opnd_a;
        word_t     opnd_b;
        word_t     rs1_val;
        word_t     rs2_val;
    } issue_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [7:0] wmask;
    } mem_req_t;

    typedef struct packed {
        logic                 wen;
        logic [reg_idx_w-1:0] id;
        word_t                value;
    } rd_write_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage
